// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        NOP    = 7'd0,
        ADDU   = 7'd1,
        SUBU   = 7'd2,
        AND    = 7'd3,
        OR     = 7'd4,
        XOR    = 7'd5,
        SLT    = 7'd6,
        ADDIU  = 7'd7,
        ANDI   = 7'd8,
        ORI    = 7'd9,
        LUI    = 7'd10,
        BEQ    = 7'd30,  // Control flow keeps the legacy numbering
        BGEZ   = 7'd31,
        BGEZAL = 7'd32,
        BGTZ   = 7'd33,
        BLEZ   = 7'd34,
        BLTZ   = 7'd35,
        BLTZAL = 7'd36,
        BNE    = 7'd37,
        J      = 7'd38,
        JAL    = 7'd39,
        JALR   = 7'd40,
        JR     = 7'd41
    } instr_code_t;

    typedef struct packed {
        instr_code_t code;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic        write_en;
        logic        use_imm;
        logic [15:0] imm;
        logic [25:0] instr_index;
        logic        cmp_zero;  // Branch compares rs against zero
    } decode_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  idx;
        logic [31:0] data;
    } rf_write_t;

    localparam logic [31:0] BOOT_VECTOR = 32'hBFC0_0000;
    localparam logic [4:0]  LINK_REG    = 5'd31;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MIPS32 encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_LUI     = 6'h0F;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    // REGIMM selectors live in the rt field
    localparam logic [4:0] RT_BLTZ   = 5'h00;
    localparam logic [4:0] RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10;
    localparam logic [4:0] RT_BGEZAL = 5'h11;

endpackage

`default_nettype wire

// ==== rtl/phase_control.sv ====
`default_nettype none
`timescale 1ns/1ns

module phase_control (
    input  logic        clk,
    input  logic        reset,
    input  logic        halted,
    output logic        fetch,
    output logic        exec1,
    output logic        exec2,
    input  logic [31:0] imem_data,
    output logic [31:0] instr
);

    typedef enum logic [1:0] {
        PH_FETCH,
        PH_EXEC1,
        PH_EXEC2
    } phase_t;

    phase_t phase;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PH_FETCH;
        end else begin
            case (phase)
                PH_FETCH: phase <= halted ? PH_FETCH : PH_EXEC1;  // Park here once halted
                PH_EXEC1: phase <= PH_EXEC2;
                default:  phase <= PH_FETCH;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (fetch) begin
            instr <= imem_data;
        end
    end

    assign fetch = (phase == PH_FETCH);
    assign exec1 = (phase == PH_EXEC1);
    assign exec2 = (phase == PH_EXEC2);

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`default_nettype none
`timescale 1ns/1ns

module instr_decoder import cpu_pkg::*; (
    input  logic [31:0] instr,
    output decode_t     dec
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rd;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rd     = instr[15:11];

    always_comb begin
        dec             = '0;
        dec.code        = NOP;
        dec.rs          = instr[25:21];
        dec.rt          = instr[20:16];
        dec.imm         = instr[15:0];
        dec.instr_index = instr[25:0];

        case (opcode)
            OP_SPECIAL: begin
                dec.dest     = rd;
                dec.write_en = 1'b1;
                case (funct)
                    FN_ADDU: dec.code = ADDU;
                    FN_SUBU: dec.code = SUBU;
                    FN_AND:  dec.code = AND;
                    FN_OR:   dec.code = OR;
                    FN_XOR:  dec.code = XOR;
                    FN_SLT:  dec.code = SLT;
                    FN_JALR: dec.code = JALR;  // Return address into rd
                    FN_JR: begin
                        dec.code     = JR;
                        dec.write_en = 1'b0;
                    end
                    FN_SLL: begin
                        dec.code     = NOP;  // Only the all-zero shift is used
                        dec.write_en = 1'b0;
                    end
                    default: dec.write_en = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                dec.cmp_zero = 1'b1;
                case (dec.rt)
                    RT_BLTZ: dec.code = BLTZ;
                    RT_BGEZ: dec.code = BGEZ;
                    RT_BLTZAL: begin
                        dec.code     = BLTZAL;
                        dec.dest     = LINK_REG;
                        dec.write_en = 1'b1;
                    end
                    RT_BGEZAL: begin
                        dec.code     = BGEZAL;
                        dec.dest     = LINK_REG;
                        dec.write_en = 1'b1;
                    end
                    default: dec.cmp_zero = 1'b0;
                endcase
            end
            OP_J: dec.code = J;
            OP_JAL: begin
                dec.code     = JAL;
                dec.dest     = LINK_REG;
                dec.write_en = 1'b1;
            end
            OP_BEQ: dec.code = BEQ;
            OP_BNE: dec.code = BNE;
            OP_BLEZ: begin
                dec.code     = BLEZ;
                dec.cmp_zero = 1'b1;
            end
            OP_BGTZ: begin
                dec.code     = BGTZ;
                dec.cmp_zero = 1'b1;
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                dec.dest     = dec.rt;  // Immediate forms write rt
                dec.write_en = 1'b1;
                dec.use_imm  = 1'b1;
                case (opcode)
                    OP_ADDIU: dec.code = ADDIU;
                    OP_ANDI:  dec.code = ANDI;
                    OP_ORI:   dec.code = ORI;
                    default:  dec.code = LUI;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`default_nettype none
`timescale 1ns/1ns

module register_file import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  rf_write_t   wr
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.idx != 5'd0)) begin
            regs[wr.idx] <= wr.data;  // $zero stays zero
        end
    end

    // Asynchronous read, no write bypass
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`default_nettype none
`timescale 1ns/1ns

module exec_unit import cpu_pkg::*; (
    input  logic        exec2,
    input  decode_t     dec,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    input  logic [31:0] link_addr,
    output logic        zero,
    output logic        positive,
    output logic        negative,
    output rf_write_t   wr
);

    logic [31:0] imm_ext;
    logic [31:0] operand_b;
    logic [31:0] cmp_b;
    logic [31:0] result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cmp_b    = dec.cmp_zero ? 32'd0 : rt_data;
    assign zero     = (rs_data == cmp_b);
    assign positive = ($signed(rs_data) > $signed(cmp_b));
    assign negative = ($signed(rs_data) < $signed(cmp_b));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (dec.code)
            ADDIU:     imm_ext = {{16{dec.imm[15]}}, dec.imm};
            LUI:       imm_ext = {dec.imm, 16'h0000};
            default:   imm_ext = {16'h0000, dec.imm};  // ANDI, ORI
        endcase
    end

    assign operand_b = dec.use_imm ? imm_ext : rt_data;

    always_comb begin
        case (dec.code)
            ADDU, ADDIU: result = rs_data + operand_b;
            SUBU:        result = rs_data - operand_b;
            AND, ANDI:   result = rs_data & operand_b;
            OR, ORI:     result = rs_data | operand_b;
            XOR:         result = rs_data ^ operand_b;
            SLT:         result = {31'd0, $signed(rs_data) < $signed(operand_b)};
            LUI:         result = operand_b;
            JAL, JALR, BGEZAL, BLTZAL:
                         result = link_addr;  // Written taken or not
            default:     result = 32'd0;
        endcase
    end

    assign wr.en   = dec.write_en & exec2;
    assign wr.idx  = dec.dest;
    assign wr.data = result;

endmodule

`default_nettype wire

// ==== rtl/program_counter.sv ====
`default_nettype none
`timescale 1ns/1ns

module program_counter import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch,
    input  logic        exec1,
    input  logic        exec2,
    input  instr_code_t code,
    input  logic [15:0] offset,
    input  logic [25:0] instr_index,
    input  logic [31:0] register_data,
    input  logic        zero,
    input  logic        positive,
    input  logic        negative,
    output logic [31:0] address,
    output logic        pc_halt
);

    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] jump_target_reg;
    logic        jump;
    logic        jump_flag;

    // Offset is relative to the next instruction, which address already holds
    assign branch_target = address + {{14{offset[15]}}, offset, 2'b00};

    always_comb begin
        jump        = 1'b0;
        jump_target = branch_target;
        case (code)
            BEQ:            jump = zero;
            BNE:            jump = positive | negative;
            BLEZ:           jump = zero | negative;
            BGTZ:           jump = positive;
            BGEZ, BGEZAL:   jump = positive | zero;
            BLTZ, BLTZAL:   jump = negative;
            J, JAL: begin
                jump        = 1'b1;
                jump_target = {address[31:28], instr_index, 2'b00};
            end
            JR, JALR: begin
                jump        = 1'b1;
                jump_target = register_data;
            end
            default: ;
        endcase
    end

    assign pc_halt = (address == 32'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            address   <= BOOT_VECTOR;
            jump_flag <= 1'b0;
        end else if (fetch) begin
            if (pc_halt) begin
                address <= 32'd0;  // Halt is sticky
            end else if (jump_flag) begin
                address <= jump_target_reg;
            end else begin
                address <= address + 32'd4;
            end
        end else if (exec1) begin
            jump_flag <= 1'b0;  // Consumed by the last fetch
        end else if (exec2) begin
            jump_flag <= jump;
        end
    end

    always_ff @(posedge clk) begin
        if (exec2) begin
            jump_target_reg <= jump_target;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpu_core import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic        halted,
    output rf_write_t   rf_wr
);

    logic        fetch;
    logic        exec1;
    logic        exec2;
    logic [31:0] instr;
    decode_t     dec;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        zero;
    logic        positive;
    logic        negative;

    phase_control i_phase_control (
        .clk       (clk),
        .reset     (reset),
        .halted    (halted),
        .fetch     (fetch),
        .exec1     (exec1),
        .exec2     (exec2),
        .imem_data (imem_data),
        .instr     (instr)
    );

    instr_decoder i_instr_decoder (
        .instr (instr),
        .dec   (dec)
    );

    register_file i_register_file (
        .clk     (clk),
        .reset   (reset),
        .rs      (dec.rs),
        .rt      (dec.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr      (rf_wr)
    );

    exec_unit i_exec_unit (
        .exec2     (exec2),
        .dec       (dec),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .link_addr (imem_addr),  // Next instruction during exec
        .zero      (zero),
        .positive  (positive),
        .negative  (negative),
        .wr        (rf_wr)
    );

    program_counter i_program_counter (
        .clk           (clk),
        .reset         (reset),
        .fetch         (fetch),
        .exec1         (exec1),
        .exec2         (exec2),
        .code          (dec.code),
        .offset        (dec.imm),
        .instr_index   (dec.instr_index),
        .register_data (rs_data),
        .zero          (zero),
        .positive      (positive),
        .negative      (negative),
        .address       (imem_addr),
        .pc_halt       (halted)
    );

endmodule

`default_nettype wire

// ==== testbench/cpu_core_asserts.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpu_core_asserts import cpu_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        fetch,
    input logic [31:0] address
);

    a_aligned: assert property (@(posedge clk) disable iff (reset)
        address[1:0] == 2'b00)
        else $error("program counter is not word aligned");

    // Only the fetch edge moves the address
    a_change_after_fetch: assert property (@(posedge clk) disable iff (reset)
        !$stable(address) |-> ($past(fetch) || $past(reset)))
        else $error("program counter changed outside the fetch edge");

    a_boot_vector: assert property (@(posedge clk)
        reset |=> (address == BOOT_VECTOR))
        else $error("program counter is not at the boot vector after reset");

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
        (address == 32'd0) |=> (address == 32'd0))
        else $error("program counter left the halt address");

endmodule

bind program_counter cpu_core_asserts i_cpu_core_asserts (
    .clk     (clk),
    .reset   (reset),
    .fetch   (fetch),
    .address (address)
);

`default_nettype wire

// ==== testbench/cpu_core_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpu_core_tb import cpu_pkg::*; ();

    typedef enum int {S_ALU, S_BRANCH, S_JUMP, S_LUI, S_ORI, S_JALR, S_HALT} slot_t;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        halted;
    rf_write_t   rf_wr;

    logic [31:0] prog [60];
    slot_t       slot_kind [60];
    int          prog_len = $size(prog);
    logic [31:0] rng_state = 32'd74;
    logic [31:0] model_regs [32];
    logic [31:0] exp_addr [$];
    rf_write_t   exp_wr [$];
    logic [31:0] last_addr;
    int          wr_count = 0;
    int          model_writes = 0;
    logic [11:0] ctrl_seen;  // One bit per control flow code
    logic [3:0]  link_seen;  // Linking branch form and outcome

    cpu_core i_cpu_core (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .halted    (halted),
        .rf_wr     (rf_wr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("[FAIL] %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [4:0] rand_src();
        return 5'(next_random() % 32'd16);
    endfunction

    function automatic logic [4:0] rand_dest();
        return 5'(next_random() % 32'd15 + 32'd1);  // Never r0
    endfunction

    function automatic logic [31:0] alu_word();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] w;
        rs  = rand_src();
        rt  = rand_src();
        rd  = rand_dest();
        imm = 16'(next_random());
        case (next_random() % 32'd11)
            0:       w = 32'd0;  // SLL r0 as NOP
            1:       w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
            2:       w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SUBU};
            3:       w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_AND};
            4:       w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_OR};
            5:       w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_XOR};
            6:       w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLT};
            7:       w = {OP_ADDIU, rs, rd, imm};
            8:       w = {OP_ANDI, rs, rd, imm};
            9:       w = {OP_ORI, rs, rd, imm};
            default: w = {OP_LUI, 5'd0, rd, imm};
        endcase
        return w;
    endfunction

    function automatic logic [31:0] branch_word(int off);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        logic [31:0] w;
        rs  = rand_src();
        rt  = (next_random() % 32'd3 == 32'd0) ? rs : rand_src();  // Some equal pairs
        imm = 16'(off);
        case (next_random() % 32'd8)
            0:       w = {OP_BEQ, rs, rt, imm};
            1:       w = {OP_BNE, rs, rt, imm};
            2:       w = {OP_BLEZ, rs, 5'd0, imm};
            3:       w = {OP_BGTZ, rs, 5'd0, imm};
            4:       w = {OP_REGIMM, rs, RT_BLTZ, imm};
            5:       w = {OP_REGIMM, rs, RT_BGEZ, imm};
            6:       w = {OP_REGIMM, rs, RT_BLTZAL, imm};
            default: w = {OP_REGIMM, rs, RT_BGEZAL, imm};
        endcase
        return w;
    endfunction

    // Forward slot that skips only plain ALU slots
    function automatic int pick_target(int first);
        int t;
        int limit;
        t     = first;
        limit = first + int'(next_random() % 32'd10);
        while (t < limit && slot_kind[t] == S_ALU) begin
            t = t + 1;
        end
        return t;
    endfunction

    task automatic build_program();
        int          i;
        int          t;
        int          r;
        logic [31:0] a;
        i = 0;
        while (i < prog_len - 1) begin
            r = int'(next_random() % 32'd10);
            if (i < prog_len - 8 && r >= 3 && r < 9) begin
                slot_kind[i]     = (r == 8) ? S_JUMP : S_BRANCH;
                slot_kind[i + 1] = S_ALU;  // Slot after control flow is plain ALU
                i = i + 2;
            end else if (i < prog_len - 8 && r == 9) begin
                slot_kind[i]     = S_LUI;
                slot_kind[i + 1] = S_ORI;
                slot_kind[i + 2] = S_JALR;
                slot_kind[i + 3] = S_ALU;
                i = i + 4;
            end else begin
                slot_kind[i] = S_ALU;
                i = i + 1;
            end
        end
        slot_kind[prog_len - 1] = S_HALT;
        for (i = 0; i < prog_len; i++) begin
            case (slot_kind[i])
                S_ALU:    prog[i] = alu_word();
                S_BRANCH: prog[i] = branch_word(pick_target(i + 2) - i - 1);
                S_JUMP: begin
                    a = BOOT_VECTOR + 32'(4 * pick_target(i + 2));
                    prog[i] = {(next_random() % 32'd2 == 32'd0) ? OP_J : OP_JAL, a[27:2]};
                end
                S_LUI: begin
                    t = pick_target(i + 4);
                    a = BOOT_VECTOR + 32'(4 * t);
                    prog[i]     = {OP_LUI, 5'd0, 5'd20, a[31:16]};  // r20 holds the target
                    prog[i + 1] = {OP_ORI, 5'd20, 5'd20, a[15:0]};
                    prog[i + 2] = {OP_SPECIAL, 5'd20, 5'd0, rand_dest(), 5'd0, FN_JALR};
                end
                S_HALT:   prog[i] = {OP_SPECIAL, 20'd0, FN_JR};
                default: ;
            endcase
        end
    endtask

    function automatic logic [31:0] imem_word(logic [31:0] addr);
        logic [31:0] off;
        off = addr - BOOT_VECTOR;
        if (off < 32'(4 * prog_len)) begin
            return prog[off[7:2]];
        end
        return 32'd0;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] tgt;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm_s;
        logic        pend;
        logic        wen;
        logic        take;
        logic [4:0]  dst;
        int          steps;
        int          kind;
        exp_addr.delete();
        exp_wr.delete();
        ctrl_seen = '0;
        link_seen = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        pc    = BOOT_VECTOR;
        tgt   = 32'd0;
        pend  = 1'b0;
        steps = 0;
        while (pc != 32'd0) begin
            steps = steps + 1;
            if (steps > 1000) begin
                stop_with_error("reference model never reached address 0");
            end
            ins = imem_word(pc);
            pc  = pend ? tgt : pc + 32'd4;  // Pending jump lands one fetch late
            exp_addr.push_back(pc);
            a     = model_regs[ins[25:21]];
            b     = model_regs[ins[20:16]];
            imm_s = {{16{ins[15]}}, ins[15:0]};
            tgt   = pc + {imm_s[29:0], 2'b00};
            wen   = 1'b0;
            take  = 1'b0;
            dst   = ins[20:16];
            res   = pc;  // Link value
            kind  = -1;
            case (ins[31:26])
                OP_SPECIAL: begin
                    dst = ins[15:11];
                    wen = 1'b1;
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        FN_JALR: begin
                            take = 1'b1;
                            tgt  = a;
                            kind = 10;
                        end
                        FN_JR: begin
                            wen  = 1'b0;
                            take = 1'b1;
                            tgt  = a;
                            kind = 11;
                        end
                        default: wen = 1'b0;
                    endcase
                end
                OP_REGIMM: begin
                    take = ins[16] ? !a[31] : a[31];
                    wen  = ins[20];  // AL forms link even when not taken
                    dst  = LINK_REG;
                    kind = 4 + 2 * int'(ins[20]) + int'(ins[16]);
                    if (ins[20]) begin
                        link_seen[{ins[16], take}] = 1'b1;
                    end
                end
                OP_J, OP_JAL: begin
                    take = 1'b1;
                    tgt  = {pc[31:28], ins[25:0], 2'b00};
                    wen  = (ins[31:26] == OP_JAL);
                    dst  = LINK_REG;
                    kind = (ins[31:26] == OP_JAL) ? 9 : 8;
                end
                OP_BEQ: begin
                    take = (a == b);
                    kind = 0;
                end
                OP_BNE: begin
                    take = (a != b);
                    kind = 1;
                end
                OP_BLEZ: begin
                    take = a[31] || (a == 32'd0);
                    kind = 2;
                end
                OP_BGTZ: begin
                    take = !a[31] && (a != 32'd0);
                    kind = 3;
                end
                OP_ADDIU: begin
                    wen = 1'b1;
                    res = a + imm_s;
                end
                OP_ANDI: begin
                    wen = 1'b1;
                    res = a & {16'd0, ins[15:0]};
                end
                OP_ORI: begin
                    wen = 1'b1;
                    res = a | {16'd0, ins[15:0]};
                end
                OP_LUI: begin
                    wen = 1'b1;
                    res = {ins[15:0], 16'd0};
                end
                default: ;
            endcase
            if (kind >= 0) begin
                ctrl_seen[kind] = 1'b1;
            end
            pend = take;
            if (wen) begin
                exp_wr.push_back({1'b1, dst, res});
                if (dst != 5'd0) begin
                    model_regs[dst] = res;
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitor and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic watch_cycle();
        rf_write_t w;
        if (rf_wr.en) begin
            if (exp_wr.size() == 0) begin
                stop_with_error("register write seen but the model expects none");
            end
            w = exp_wr.pop_front();
            check("rf_wr.idx", 32'(w.idx), 32'(rf_wr.idx));
            check("rf_wr.data", w.data, rf_wr.data);
            wr_count = wr_count + 1;
        end
        if (imem_addr !== last_addr) begin
            if (exp_addr.size() == 0) begin
                stop_with_error("imem_addr changed but the model expects no more fetches");
            end
            check("imem_addr", exp_addr.pop_front(), imem_addr);
            last_addr = imem_addr;
        end
        imem_data = imem_word(imem_addr);  // Memory answers the current address
    endtask

    initial begin
        int cycles;
        int attempts;
        reset     = 1'b1;
        imem_data = 32'd0;
        attempts  = 0;
        // Draw programs until one runs every control flow form
        do begin
            attempts = attempts + 1;
            if (attempts > 5000) begin
                stop_with_error("no random program ran every control flow form");
            end
            build_program();
            run_model();
        end while (ctrl_seen != 12'hFFF || link_seen != 4'hF);
        model_writes = exp_wr.size();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check("reset imem_addr", BOOT_VECTOR, imem_addr);
        check("reset halted", 32'd0, 32'(halted));
        check("reset rf_wr.en", 32'd0, 32'(rf_wr.en));
        last_addr = imem_addr;
        imem_data = imem_word(imem_addr);
        reset     = 1'b0;
        cycles    = 0;
        while (!halted) begin
            @(negedge clk);
            watch_cycle();
            cycles = cycles + 1;
            if (cycles > 3000) begin
                stop_with_error("timeout waiting for the core to halt");
            end
        end
        check("halt imem_addr", 32'd0, imem_addr);
        repeat (20) begin
            @(negedge clk);
            check("imem_addr after halt", 32'd0, imem_addr);
            check("halted after halt", 32'd1, 32'(halted));
            if (rf_wr.en) begin
                stop_with_error("register write after the core halted");
            end
        end
        check("write count", 32'(model_writes), 32'(wr_count));
        check("unconsumed addresses", 32'd0, 32'(exp_addr.size()));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/cpu_pkg.sv
rtl/phase_control.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/exec_unit.sv
rtl/program_counter.sv
rtl/cpu_core.sv
testbench/cpu_core_asserts.sv
testbench/cpu_core_tb.sv

// ==== Makefile ====
TOP := cpu_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
